// File: vlog.f
design/eth_tx_pkg.sv
design/eth_tx_loader.sv
design/eth_tx_queue.sv
design/eth_tx_mux.sv
design/eth_tx_fcs.sv
design/eth_tx_top.sv
verif/eth_tx_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = eth_tx_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/eth_tx_tb.sv
`default_nettype none

module eth_tx_tb;

  import eth_tx_pkg::*;

  localparam int TIMEOUT    = 2000;  // Cycles allowed per wait
  localparam int MAX_FRAMES = 32;

  logic      clk;
  logic      rst;
  logic      wr_en;
  chan_t     wr_chan;
  byte_t     wr_dat;
  meta_t     wr_meta;
  logic      wr_last;
  logic      tx_en;
  chan_vec_t q_busy;
  logic      load_err;
  byte_t     tx_dat;
  logic      tx_val;
  logic      tx_sof;
  logic      tx_eof;
  meta_t     tx_meta;

  logic [15:0] lfsr;
  int          err_count = 0;  // load_err pulses seen

  // Loaded frames in load order
  byte_t exp_dat [MAX_FRAMES][QUEUE_DEPTH];
  int    exp_len [MAX_FRAMES];
  meta_t exp_meta [MAX_FRAMES];
  chan_t exp_chan [MAX_FRAMES];
  logic  exp_done [MAX_FRAMES];
  int    n_exp = 0;

  // Last frame captured on tx, FCS included
  byte_t got_dat [QUEUE_DEPTH + 4];
  int    got_len;
  meta_t got_meta;

  eth_tx_top UUT (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_chan  (wr_chan),
    .wr_dat   (wr_dat),
    .wr_meta  (wr_meta),
    .wr_last  (wr_last),
    .tx_en    (tx_en),
    .q_busy   (q_busy),
    .load_err (load_err),
    .tx_dat   (tx_dat),
    .tx_val   (tx_val),
    .tx_sof   (tx_sof),
    .tx_eof   (tx_eof),
    .tx_meta  (tx_meta)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (!rst && load_err)
      err_count = err_count + 1;
  end

  task automatic stop_run();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic fail_with(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic value_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp)
      value_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_meta(input meta_t got, input meta_t exp, input string what);
    if (got !== exp)
      value_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_crc(input crc_t got, input crc_t exp, input string what);
    if (got !== exp)
      value_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_chan_vec(input chan_vec_t got, input chan_vec_t exp, input string what);
    if (got !== exp)
      value_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic int rand_bits(input int n);
    int   r;
    logic fb;
    r = 0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = (r << 1) | int'(fb);
    end
    return r;
  endfunction

  // Serial reflected CRC-32, data LSB first
  function automatic crc_t crc_byte(input crc_t c, input byte_t d);
    crc_t r;
    logic fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[0] ^ d[i];
      r  = r >> 1;
      if (fb)
        r = r ^ 32'hEDB8_8320;
    end
    return r;
  endfunction

  function automatic crc_t ref_fcs(input int idx);
    crc_t c;
    c = 32'hFFFF_FFFF;
    for (int k = 0; k < exp_len[idx]; k++)
      c = crc_byte(c, exp_dat[idx][k]);
    return ~c;
  endfunction

  // Channel number kept in the low metadata bits to identify frames on tx
  task automatic make_frame(input chan_t c, input int len, output int idx);
    idx = n_exp;
    n_exp++;
    exp_chan[idx] = c;
    exp_len[idx]  = len;
    exp_done[idx] = 1'b0;
    exp_meta[idx] = meta_t'(rand_bits(14) << 2) | meta_t'(c);
    for (int k = 0; k < len; k++)
      exp_dat[idx][k] = byte_t'(rand_bits(8));
  endtask

  // A bad byte aimed at the next channel goes before every bad_step-th byte
  task automatic drive_frame(input int idx, input int bad_step, output int n_bad);
    int    t;
    chan_t c;
    c     = exp_chan[idx];
    n_bad = 0;
    for (int k = 0; k < exp_len[idx]; k++) begin
      if (bad_step > 0 && k > 0 && (k % bad_step) == 0) begin
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_chan <= chan_t'((int'(c) + 1) % N_CHAN);
        wr_dat  <= byte_t'(rand_bits(8));
        wr_meta <= ~exp_meta[idx];
        wr_last <= 1'b0;
        n_bad++;
      end
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_chan <= c;
      wr_dat  <= exp_dat[idx][k];
      wr_meta <= (k == 0) ? exp_meta[idx] : ~exp_meta[idx];  // Only opening byte counts
      wr_last <= (k == exp_len[idx] - 1);
    end
    @(posedge clk);
    wr_en   <= 1'b0;
    wr_last <= 1'b0;
    t = 0;
    while (!q_busy[c]) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT)
        fail_with("Timeout while waiting for q_busy after loading a frame");
    end
  endtask

  task automatic capture_frame();
    int   t;
    logic done;
    got_len = 0;
    done    = 1'b0;
    t       = 0;
    @(negedge clk);
    while (!(tx_val && tx_sof)) begin
      if (t > TIMEOUT)
        fail_with("Timeout while waiting for tx_sof");
      t++;
      @(negedge clk);
    end
    got_meta = tx_meta;
    t = 0;
    while (!done) begin
      if (tx_val) begin
        if (got_len == QUEUE_DEPTH + 4)
          fail_with("Frame on tx is longer than the longest body plus FCS");
        got_dat[got_len] = tx_dat;
        got_len++;
        check_meta(tx_meta, got_meta, "tx_meta during frame");
        done = tx_eof;
      end
      if (!done) begin
        if (t > TIMEOUT)
          fail_with("Timeout while waiting for tx_eof");
        t++;
        @(negedge clk);
        if (tx_sof)
          fail_with("tx_sof arrived inside an open frame");
      end
    end
  endtask

  // Matches the oldest pending frame of the channel, so per-channel order is checked
  task automatic receive_frame(output int idx);
    chan_t c;
    capture_frame();
    c   = chan_t'(got_meta[1:0]);
    idx = -1;
    for (int i = n_exp - 1; i >= 0; i--) begin
      if (!exp_done[i] && exp_chan[i] == c)
        idx = i;
    end
    if (idx < 0)
      fail_with($sformatf("Frame with metadata %h matches no loaded frame", got_meta));
    if (got_len != exp_len[idx] + 4)
      value_error($sformatf("tx frame has %0d bytes, expected %0d", got_len, exp_len[idx] + 4));
    check_meta(got_meta, exp_meta[idx], "tx_meta");
    for (int k = 0; k < exp_len[idx]; k++)
      check_byte(got_dat[k], exp_dat[idx][k], $sformatf("body byte %0d", k));
    check_crc({got_dat[got_len-1], got_dat[got_len-2], got_dat[got_len-3], got_dat[got_len-4]},
              ref_fcs(idx), "FCS");
    exp_done[idx] = 1'b1;
  endtask

  task automatic expect_channel(input int idx, input chan_t c);
    check_chan_vec(chan_vec_t'(1) << exp_chan[idx], chan_vec_t'(1) << c, "channel of tx frame");
  endtask

  task automatic single_frames();
    int    lens [3];
    int    idx;
    int    got;
    int    nb;
    chan_t c;
    lens = '{1, QUEUE_DEPTH, 1 + rand_bits(6)};
    @(posedge clk);
    tx_en <= 1'b1;
    for (int n = 0; n < 3; n++) begin
      c = chan_t'(rand_bits(2) % N_CHAN);
      make_frame(c, lens[n], idx);
      drive_frame(idx, 0, nb);
      receive_frame(got);
      expect_channel(got, c);
    end
  endtask

  task automatic priority_order();
    int idx;
    int got;
    int nb;
    @(posedge clk);
    tx_en <= 1'b0;
    for (int c = 0; c < N_CHAN; c++) begin
      make_frame(chan_t'(c), 4 + rand_bits(4), idx);
      drive_frame(idx, 0, nb);
    end
    check_chan_vec(q_busy, 3'b111, "q_busy with three frames waiting");
    @(posedge clk);
    tx_en <= 1'b1;
    receive_frame(got);
    expect_channel(got, 2);
    receive_frame(got);
    expect_channel(got, 1);
    receive_frame(got);
    expect_channel(got, 0);
  endtask

  task automatic late_arrival();
    int idx0;
    int idx2;
    int got0;
    int got2;
    int nb;
    int t;
    make_frame(0, 48, idx0);
    make_frame(2, 6, idx2);
    drive_frame(idx0, 0, nb);
    fork
      begin
        receive_frame(got0);
        receive_frame(got2);
      end
      begin
        t = 0;
        @(negedge clk);
        while (!tx_sof) begin
          if (t > TIMEOUT)
            fail_with("Timeout while waiting for channel 0 to start");
          t++;
          @(negedge clk);
        end
        drive_frame(idx2, 0, nb);  // Loaded while channel 0 is on tx
      end
    join
    expect_channel(got0, 0);
    expect_channel(got2, 2);
  endtask

  task automatic busy_status();
    int idx;
    int got;
    int nb;
    @(posedge clk);
    tx_en <= 1'b0;
    check_chan_vec(q_busy, 3'b000, "q_busy when idle");
    make_frame(1, 10, idx);
    drive_frame(idx, 0, nb);
    check_chan_vec(q_busy, 3'b010, "q_busy after channel 1 load");
    make_frame(2, 10, idx);
    drive_frame(idx, 0, nb);
    check_chan_vec(q_busy, 3'b110, "q_busy after channel 2 load");
    @(posedge clk);
    tx_en <= 1'b1;
    receive_frame(got);
    expect_channel(got, 2);
    check_chan_vec(q_busy, 3'b010, "q_busy after channel 2 tx_eof");
    receive_frame(got);
    expect_channel(got, 1);
    check_chan_vec(q_busy, 3'b000, "q_busy after channel 1 tx_eof");
  endtask

  task automatic channel_switch();
    int idx;
    int got;
    int nb;
    int base;
    base = err_count;
    make_frame(chan_t'(rand_bits(2) % N_CHAN), 20, idx);
    drive_frame(idx, 3, nb);
    receive_frame(got);
    if (err_count - base != nb)
      value_error($sformatf("load_err pulsed %0d times, expected %0d", err_count - base, nb));
  endtask

  task automatic back_to_back();
    int    idx;
    int    got;
    int    nb;
    int    t;
    logic  found;
    chan_t c;
    fork
      for (int n = 0; n < 20; n++) begin
        c     = chan_t'(rand_bits(2) % N_CHAN);
        found = 1'b0;
        t     = 0;
        @(negedge clk);
        while (!found) begin
          for (int j = 0; j < N_CHAN; j++) begin
            if (!found && !q_busy[(int'(c) + j) % N_CHAN]) begin
              c     = chan_t'((int'(c) + j) % N_CHAN);
              found = 1'b1;
            end
          end
          if (!found) begin
            if (t > TIMEOUT)
              fail_with("Timeout while waiting for a free queue");
            t++;
            @(negedge clk);
          end
        end
        make_frame(c, 1 + rand_bits(6), idx);
        drive_frame(idx, 0, nb);
      end
      repeat (20) receive_frame(got);
    join
  endtask

  initial begin
    string s;
    crc_t  c;
    rst     = 1'b1;
    wr_en   = 1'b0;
    wr_chan = '0;
    wr_dat  = '0;
    wr_meta = '0;
    wr_last = 1'b0;
    tx_en   = 1'b0;
    lfsr    = 16'd62249;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // Known check value of the reference CRC
    s = "123456789";
    c = 32'hFFFF_FFFF;
    for (int i = 0; i < s.len(); i++)
      c = crc_byte(c, byte_t'(s[i]));
    check_crc(~c, 32'hCBF4_3926, "reference CRC of check string");
    single_frames();
    priority_order();
    late_arrival();
    busy_status();
    channel_switch();
    back_to_back();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/eth_tx_top.sv
`default_nettype none

module eth_tx_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_en,
  input  eth_tx_pkg::chan_t     wr_chan,
  input  eth_tx_pkg::byte_t     wr_dat,
  input  eth_tx_pkg::meta_t     wr_meta,
  input  logic                  wr_last,
  input  logic                  tx_en,
  output eth_tx_pkg::chan_vec_t q_busy,
  output logic                  load_err,
  output eth_tx_pkg::byte_t     tx_dat,
  output logic                  tx_val,
  output logic                  tx_sof,
  output logic                  tx_eof,
  output eth_tx_pkg::meta_t     tx_meta
);

  import eth_tx_pkg::*;

  // Loader to queues
  chan_vec_t q_wr;
  byte_t     q_dat;
  meta_t     q_meta;
  logic      q_last;

  // Queues to mux
  byte_t [N_CHAN-1:0] ch_dat;
  meta_t [N_CHAN-1:0] ch_meta;
  chan_vec_t          ch_val;
  chan_vec_t          ch_sof;
  chan_vec_t          ch_eof;
  chan_vec_t          ch_rdy;
  chan_vec_t          ch_req;

  // Mux to FCS
  byte_t dat_mux;
  meta_t meta_mux;
  logic  val_mux;
  logic  sof_mux;
  logic  eof_mux;
  logic  rdy_mux;
  logic  req_mux;

  eth_tx_loader u_loader (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_chan  (wr_chan),
    .wr_dat   (wr_dat),
    .wr_meta  (wr_meta),
    .wr_last  (wr_last),
    .q_wr     (q_wr),
    .q_dat    (q_dat),
    .q_meta   (q_meta),
    .q_last   (q_last),
    .load_err (load_err)
  );

  for (genvar i = 0; i < N_CHAN; i++) begin : g_queue
    eth_tx_queue u_queue (
      .clk     (clk),
      .rst     (rst),
      .wr      (q_wr[i]),
      .wr_dat  (q_dat),
      .wr_meta (q_meta),
      .wr_last (q_last),
      .req     (ch_req[i]),
      .busy    (q_busy[i]),
      .dat     (ch_dat[i]),
      .val     (ch_val[i]),
      .sof     (ch_sof[i]),
      .eof     (ch_eof[i]),
      .rdy     (ch_rdy[i]),
      .meta    (ch_meta[i])
    );
  end

  eth_tx_mux u_mux (
    .clk      (clk),
    .rst      (rst),
    .dat      (ch_dat),
    .val      (ch_val),
    .sof      (ch_sof),
    .eof      (ch_eof),
    .rdy      (ch_rdy),
    .meta     (ch_meta),
    .req_mux  (req_mux),
    .req      (ch_req),
    .dat_mux  (dat_mux),
    .val_mux  (val_mux),
    .sof_mux  (sof_mux),
    .eof_mux  (eof_mux),
    .rdy_mux  (rdy_mux),
    .meta_mux (meta_mux)
  );

  eth_tx_fcs u_fcs (
    .clk      (clk),
    .rst      (rst),
    .tx_en    (tx_en),
    .dat_mux  (dat_mux),
    .val_mux  (val_mux),
    .sof_mux  (sof_mux),
    .eof_mux  (eof_mux),
    .rdy_mux  (rdy_mux),
    .meta_mux (meta_mux),
    .req_mux  (req_mux),
    .tx_dat   (tx_dat),
    .tx_val   (tx_val),
    .tx_sof   (tx_sof),
    .tx_eof   (tx_eof),
    .tx_meta  (tx_meta)
  );

endmodule

`default_nettype wire

// File: design/eth_tx_fcs.sv
`default_nettype none

module eth_tx_fcs (
  input  logic              clk,
  input  logic              rst,
  input  logic              tx_en,
  input  eth_tx_pkg::byte_t dat_mux,
  input  logic              val_mux,
  input  logic              sof_mux,
  input  logic              eof_mux,
  input  logic              rdy_mux,
  input  eth_tx_pkg::meta_t meta_mux,
  output logic              req_mux,
  output eth_tx_pkg::byte_t tx_dat,
  output logic              tx_val,
  output logic              tx_sof,
  output logic              tx_eof,
  output eth_tx_pkg::meta_t tx_meta
);

  import eth_tx_pkg::*;

  fcs_state_t state;
  crc_t       crc;
  crc_t       fcs;
  logic [1:0] fcs_cnt;  // FCS byte index, low byte first

  // One byte of reflected CRC-32, LSB first
  function automatic crc_t crc_update(crc_t c, byte_t d);
    crc_t r;
    r = c ^ {24'h0, d};
    for (int k = 0; k < 8; k++)
      r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
    return r;
  endfunction

  assign fcs = ~crc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= FCS_IDLE;
      req_mux <= 1'b0;
      fcs_cnt <= '0;
      tx_val  <= 1'b0;
      tx_sof  <= 1'b0;
      tx_eof  <= 1'b0;
    end else begin
      tx_val <= 1'b0;
      tx_sof <= 1'b0;
      tx_eof <= 1'b0;
      case (state)
        FCS_IDLE: begin
          if (rdy_mux && tx_en) begin  // tx_en only gates the start
            state   <= FCS_BODY;
            req_mux <= 1'b1;
          end
        end
        FCS_BODY: begin
          tx_val <= val_mux;
          tx_sof <= val_mux && sof_mux;
          if (val_mux && eof_mux) begin
            req_mux <= 1'b0;
            fcs_cnt <= '0;
            state   <= FCS_APPEND;
          end
        end
        FCS_APPEND: begin
          tx_val  <= 1'b1;
          tx_eof  <= (fcs_cnt == 2'd3);
          fcs_cnt <= fcs_cnt + 1'b1;
          if (fcs_cnt == 2'd3)
            state <= FCS_IDLE;
        end
        default: state <= FCS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      FCS_IDLE: crc <= CRC_INIT;
      FCS_BODY: begin
        if (val_mux) begin
          crc    <= crc_update(crc, dat_mux);
          tx_dat <= dat_mux;
        end
      end
      FCS_APPEND: tx_dat <= fcs[{fcs_cnt, 3'b000} +: 8];
      default: crc <= CRC_INIT;
    endcase
    if ((state == FCS_BODY) && val_mux && sof_mux)
      tx_meta <= meta_mux;  // Held through the FCS bytes
  end

  a_sof_eof_apart : assert property (@(posedge clk) disable iff (rst) !(tx_sof && tx_eof))
    else $error("tx_sof and tx_eof on the same byte");

endmodule

`default_nettype wire

// File: design/eth_tx_mux.sv
`default_nettype none

module eth_tx_mux (
  input  logic                                        clk,
  input  logic                                        rst,
  input  eth_tx_pkg::byte_t [eth_tx_pkg::N_CHAN-1:0]  dat,
  input  eth_tx_pkg::chan_vec_t                       val,
  input  eth_tx_pkg::chan_vec_t                       sof,
  input  eth_tx_pkg::chan_vec_t                       eof,
  input  eth_tx_pkg::chan_vec_t                       rdy,
  input  eth_tx_pkg::meta_t [eth_tx_pkg::N_CHAN-1:0]  meta,
  input  logic                                        req_mux,
  output eth_tx_pkg::chan_vec_t                       req,
  output eth_tx_pkg::byte_t                           dat_mux,
  output logic                                        val_mux,
  output logic                                        sof_mux,
  output logic                                        eof_mux,
  output logic                                        rdy_mux,
  output eth_tx_pkg::meta_t                           meta_mux
);

  import eth_tx_pkg::*;

  mux_state_t state;
  chan_vec_t  cur_rdy;  // Ready vector frozen in idle
  chan_vec_t  sel_vec;
  chan_t      sel;
  logic       sel_eof;
  logic       req_on;

  // Highest set bit of the latched vector wins
  always_comb begin
    sel     = '0;
    sel_vec = '0;
    for (int i = 0; i < N_CHAN; i++) begin
      if (cur_rdy[i]) begin
        sel        = chan_t'(i);
        sel_vec    = '0;
        sel_vec[i] = 1'b1;
      end
    end
  end

  assign sel_eof = val[sel] && eof[sel];

  // Stop requesting once the last byte is seen, so a refilled queue is not read early
  assign req_on = (state == MUX_ACTIVE) && req_mux && !sel_eof && !eof_mux;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= MUX_IDLE;
      cur_rdy <= '0;
      req     <= '0;
      val_mux <= 1'b0;
      sof_mux <= 1'b0;
      eof_mux <= 1'b0;
      rdy_mux <= 1'b0;
    end else begin
      req <= req_on ? sel_vec : '0;
      case (state)
        MUX_IDLE: begin
          cur_rdy <= rdy;
          val_mux <= 1'b0;
          sof_mux <= 1'b0;
          eof_mux <= 1'b0;
          rdy_mux <= 1'b0;
          if (rdy != '0)
            state <= MUX_ACTIVE;
        end
        MUX_ACTIVE: begin
          val_mux <= val[sel];
          sof_mux <= val[sel] && sof[sel];
          eof_mux <= sel_eof;
          if (eof_mux) begin
            state   <= MUX_IDLE;
            rdy_mux <= 1'b0;
            cur_rdy <= '0;
          end else begin
            rdy_mux <= (cur_rdy != '0);
            if (!req_mux)
              cur_rdy <= rdy;  // Re-arbitrate until the FCS stage asks for data
          end
        end
        default: state <= MUX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    dat_mux  <= dat[sel];
    meta_mux <= meta[sel];
  end

  a_req_onehot : assert property (@(posedge clk) disable iff (rst) $onehot0(req))
    else $error("mux requests more than one queue");

endmodule

`default_nettype wire

// File: design/eth_tx_queue.sv
`default_nettype none

module eth_tx_queue (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr,
  input  eth_tx_pkg::byte_t wr_dat,
  input  eth_tx_pkg::meta_t wr_meta,
  input  logic              wr_last,
  input  logic              req,
  output logic              busy,
  output eth_tx_pkg::byte_t dat,
  output logic              val,
  output logic              sof,
  output logic              eof,
  output logic              rdy,
  output eth_tx_pkg::meta_t meta
);

  import eth_tx_pkg::*;

  byte_t        mem [QUEUE_DEPTH];
  queue_state_t state;
  qlen_t        len;      // Bytes stored
  qaddr_t       rd_ptr;
  logic         wr_ok;
  logic         rd_ok;
  logic         last_rd;

  // Writes past the buffer end are dropped
  assign wr_ok   = wr && (state == Q_FILL) && (len < qlen_t'(QUEUE_DEPTH));
  assign rd_ok   = req && (state != Q_FILL);
  assign last_rd = (qlen_t'(rd_ptr) == len - 1'b1);

  assign busy = (state != Q_FILL);                         // Host must not write
  assign rdy  = (state == Q_READY) || (state == Q_STREAM); // Level until eof leaves

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= Q_FILL;
      len    <= '0;
      rd_ptr <= '0;
      val    <= 1'b0;
      sof    <= 1'b0;
      eof    <= 1'b0;
    end else begin
      val <= 1'b0;
      sof <= 1'b0;
      eof <= 1'b0;
      case (state)
        Q_FILL: begin
          if (wr_ok)
            len <= len + 1'b1;
          if (wr && wr_last)
            state <= Q_READY;
        end
        Q_READY, Q_STREAM: begin
          if (req) begin
            val    <= 1'b1;
            sof    <= (state == Q_READY);
            eof    <= last_rd;
            rd_ptr <= rd_ptr + 1'b1;
            state  <= Q_STREAM;
            if (last_rd) begin
              // Frame gone, buffer free again
              state  <= Q_FILL;
              len    <= '0;
              rd_ptr <= '0;
            end
          end
        end
        default: state <= Q_FILL;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok)
      mem[qaddr_t'(len)] <= wr_dat;
    if (wr && (state == Q_FILL))
      meta <= wr_meta;
    if (rd_ok)
      dat <= mem[rd_ptr];  // Holds while req is low
  end

  a_val_after_req : assert property (@(posedge clk) disable iff (rst) val |-> $past(req))
    else $error("queue output valid without a request");

endmodule

`default_nettype wire

// File: design/eth_tx_loader.sv
`default_nettype none

module eth_tx_loader (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_en,
  input  eth_tx_pkg::chan_t     wr_chan,
  input  eth_tx_pkg::byte_t     wr_dat,
  input  eth_tx_pkg::meta_t     wr_meta,
  input  logic                  wr_last,
  output eth_tx_pkg::chan_vec_t q_wr,
  output eth_tx_pkg::byte_t     q_dat,
  output eth_tx_pkg::meta_t     q_meta,
  output logic                  q_last,
  output logic                  load_err
);

  import eth_tx_pkg::*;

  logic  frame_open;  // Between opening byte and wr_last
  chan_t cur_chan;
  meta_t cur_meta;
  logic  mismatch;
  logic  err_d;

  // Byte of an open frame aimed at another channel
  assign mismatch = frame_open && (wr_chan != cur_chan);

  always_ff @(posedge clk) begin
    if (rst) begin
      frame_open <= 1'b0;
      q_wr       <= '0;
      err_d      <= 1'b0;
      load_err   <= 1'b0;
    end else begin
      q_wr     <= '0;
      err_d    <= wr_en && mismatch;
      load_err <= err_d;  // Second stage of error pulse
      if (wr_en && !mismatch) begin
        // Matches cur_chan once open; out of range channel gives no strobe
        q_wr       <= chan_vec_t'(1) << wr_chan;
        frame_open <= !wr_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && !frame_open) begin
      cur_chan <= wr_chan;
      cur_meta <= wr_meta;
    end
    q_dat  <= wr_dat;
    q_meta <= frame_open ? cur_meta : wr_meta;
    q_last <= wr_last;
  end

  a_q_wr_onehot : assert property (@(posedge clk) disable iff (rst) $onehot0(q_wr))
    else $error("loader write strobe hits more than one queue");

endmodule

`default_nettype wire

// File: design/eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

  localparam int N_CHAN      = 3;
  localparam int QUEUE_DEPTH = 64;  // Longest frame body in bytes

  typedef logic [7:0]                           byte_t;
  typedef logic [15:0]                          meta_t;   // EtherType or similar
  typedef logic [$clog2(N_CHAN)-1:0]            chan_t;
  typedef logic [N_CHAN-1:0]                    chan_vec_t;
  typedef logic [$clog2(QUEUE_DEPTH)-1:0]       qaddr_t;
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0]     qlen_t;   // 0 to QUEUE_DEPTH
  typedef logic [31:0]                          crc_t;

  // Reflected form of 0x04C11DB7
  localparam crc_t CRC_POLY = 32'hEDB8_8320;
  localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

  typedef enum logic [1:0] {
    Q_FILL,    // Accepting writes
    Q_READY,   // Frame complete, waiting for req
    Q_STREAM   // First byte sent
  } queue_state_t;

  typedef enum logic {
    MUX_IDLE,
    MUX_ACTIVE
  } mux_state_t;

  typedef enum logic [1:0] {
    FCS_IDLE,
    FCS_BODY,
    FCS_APPEND  // Four CRC bytes
  } fcs_state_t;

endpackage

`default_nettype wire
